// File: compile.f
+incdir+dv
hdl/cpuPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/resultStage.sv
hdl/pipelineCpu.sv
dv/cpuTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f compile.f \
    && ./obj_dir/VcpuTb | tee /dev/stderr | grep -x "sim passed" > /dev/null \
    && echo "simulation run passed" \
    || { echo "simulation run failed"; exit 1; }

// File: dv/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ------------------------------
// instruction encoding
// ------------------------------
function automatic word_t encR(input logic [5:0] fn, input int rd, input int rs, input int rt);
    return {OP_RTYPE, regAddr_t'(rs), regAddr_t'(rt), regAddr_t'(rd), 5'd0, fn};
endfunction

// rt is the destination for ADDIU and LW, the store data for SW
function automatic word_t encI(input logic [5:0] op, input int rt, input int rs, input int imm);
    return {op, regAddr_t'(rs), regAddr_t'(rt), 16'(imm)};
endfunction

// ------------------------------
// directed programs
// ------------------------------
task automatic buildForwardProg();
    progWords.delete();
    progWords.push_back(encI(OP_ADDIU, 1, 0, 5));
    progWords.push_back(encI(OP_ADDIU, 2, 1, 7));     // EX/MEM path
    progWords.push_back(encR(FN_ADDU, 3, 1, 2));      // both paths at once
    progWords.push_back(encR(FN_SUBU, 4, 3, 1));
    progWords.push_back(encR(FN_AND, 5, 4, 3));
    progWords.push_back(encR(FN_OR, 6, 5, 2));
    progWords.push_back(encR(FN_XOR, 7, 6, 4));
    progWords.push_back(encR(FN_SLT, 8, 7, 3));
    progWords.push_back(encI(OP_ADDIU, 9, 0, -3));
    progWords.push_back(encR(FN_SLT, 10, 9, 1));      // signed compare
    progWords.push_back({OP_HALT, 26'd0});
endtask

task automatic buildLoadUseProg();
    progWords.delete();
    progWords.push_back(encI(OP_ADDIU, 1, 0, 16));    // base address
    progWords.push_back(encI(OP_ADDIU, 2, 0, 'h1234));
    progWords.push_back(encI(OP_SW, 2, 1, 0));
    progWords.push_back(encI(OP_LW, 3, 1, 0));
    progWords.push_back(encR(FN_ADDU, 4, 3, 3));      // load-use on rs and rt
    progWords.push_back(encI(OP_SW, 4, 1, 4));
    progWords.push_back(encI(OP_LW, 5, 1, 4));
    progWords.push_back(encR(FN_SUBU, 6, 5, 2));
    progWords.push_back(encI(OP_LW, 7, 1, 0));
    progWords.push_back(encI(OP_SW, 7, 1, 8));        // load feeds store data
    progWords.push_back(encI(OP_LW, 8, 1, 8));
    progWords.push_back({OP_HALT, 26'd0});
endtask

task automatic buildZeroRegProg();
    progWords.delete();
    progWords.push_back(encI(OP_ADDIU, 0, 0, 99));
    progWords.push_back(encI(OP_ADDIU, 1, 0, 42));
    progWords.push_back(encR(FN_ADDU, 0, 1, 1));
    progWords.push_back(encI(OP_SW, 1, 0, 0));
    progWords.push_back(encR(FN_ADDU, 2, 0, 1));      // r0 right after a write to it
    progWords.push_back(encR(FN_OR, 3, 0, 0));
    progWords.push_back(encI(OP_LW, 0, 0, 0));
    progWords.push_back(encI(OP_ADDIU, 4, 0, 1));
    progWords.push_back({OP_HALT, 26'd0});
endtask

// loads only read words that the program stored before
task automatic buildRandomProg();
    logic [5:0]  fns [6];
    logic [15:0] written;
    int          kind;
    int          slot;
    int          rd;
    int          rs;
    int          rt;
    fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
    written = '0;
    progWords.delete();
    for (int i = 0; i < 40; i++) begin
        kind = int'($urandom % 10);
        rd   = int'($urandom % 8);
        rs   = int'($urandom % 8);
        rt   = int'($urandom % 8);
        slot = int'($urandom % 16);
        if (kind >= 8 && written == '0) begin
            kind = 7;   // nothing stored yet
        end
        if (kind < 5) begin
            progWords.push_back(encR(fns[$urandom % 6], rd, rs, rt));
        end else if (kind < 7) begin
            progWords.push_back(encI(OP_ADDIU, rd, rs, int'($urandom % 65536)));
        end else if (kind == 7) begin
            written[slot] = 1'b1;
            progWords.push_back(encI(OP_SW, rt, 0, slot * 4));
        end else begin
            while (!written[slot]) begin
                slot = (slot + 1) % 16;
            end
            progWords.push_back(encI(OP_LW, rd, 0, slot * 4));
        end
    end
    progWords.push_back({OP_HALT, 26'd0});
endtask

// ------------------------------
// architectural model
// ------------------------------
task automatic runModel();
    word_t    regs [32];
    word_t    mem [256];
    word_t    instr;
    word_t    a;
    word_t    b;
    word_t    imm;
    word_t    addr;
    word_t    result;
    regAddr_t dest;
    logic     writes;
    logic     done;
    wbPort_t  entry;
    foreach (regs[i]) begin
        regs[i] = '0;
    end
    foreach (mem[i]) begin
        mem[i] = '0;
    end
    expQ.delete();
    done = 1'b0;
    for (int pc = 0; pc < progWords.size() && !done; pc++) begin
        instr  = progWords[pc];
        a      = regs[instr[25:21]];
        b      = regs[instr[20:16]];
        imm    = {{16{instr[15]}}, instr[15:0]};
        addr   = a + imm;
        dest   = instr[20:16];
        writes = 1'b0;
        result = '0;
        case (instr[31:26])
            OP_RTYPE: begin
                dest   = instr[15:11];
                writes = 1'b1;
                case (instr[5:0])
                    FN_ADDU: result = a + b;
                    FN_SUBU: result = a - b;
                    FN_AND:  result = a & b;
                    FN_OR:   result = a | b;
                    FN_XOR:  result = a ^ b;
                    FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: writes = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                result = addr;
                writes = 1'b1;
            end
            OP_LW: begin
                result = mem[addr[9:2]];    // word address
                writes = 1'b1;
            end
            OP_SW:   mem[addr[9:2]] = b;
            OP_HALT: done = 1'b1;
            default: ;
        endcase
        if (writes && dest != '0) begin
            regs[dest]  = result;
            entry.valid = 1'b1;
            entry.dest  = dest;
            entry.data  = result;
            expQ.push_back(entry);
        end
    end
endtask

`endif

// File: dv/cpuTb.sv
module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cpuPkg::*;

    logic    clk;
    logic    rst;
    logic    halt;
    logic    loadValid;
    word_t   loadData;
    logic    loadReady;
    wbPort_t retire;
    logic    endFlag;

    word_t   progWords[$];
    word_t   randomWords[$];
    wbPort_t expQ[$];        // expected retirements, oldest first
    wbPort_t expHead;
    logic    endSeen;
    int      valueErrors;
    int      otherErrors;
    int      timeoutErrors;

    `include "tbProgram.svh"

    pipelineCpu dut0 (
        .clk         (clk),
        .i_rst       (rst),
        .i_halt      (halt),
        .i_loadValid (loadValid),
        .i_loadData  (loadData),
        .o_loadReady (loadReady),
        .o_retire    (retire),
        .o_end       (endFlag)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic reportValue(input string name, input word_t expected, input word_t actual);
        valueErrors++;
        $display("Fail %s expected %h got %h", name, expected, actual);
    endtask

    // ------------------------------
    // checks
    // ------------------------------
    assert property (@(posedge clk) !halt |-> !loadReady)
        else begin
            otherErrors++;
            $display("o_loadReady was high while i_halt was low");
        end

    assert property (@(posedge clk) disable iff (rst) endFlag |-> !retire.valid)
        else begin
            otherErrors++;
            $display("a retirement appeared after o_end");
        end

    assert property (@(posedge clk) disable iff (rst) endFlag |=> endFlag)
        else begin
            otherErrors++;
            $display("o_end dropped before reset");
        end

    // retire outputs are registered, stable at the falling edge
    always @(negedge clk) begin
        if (retire.valid === 1'b1) begin
            if (expQ.size() == 0) begin
                otherErrors++;
                $display("unexpected retirement of r%0d, nothing left to retire", retire.dest);
            end else begin
                expHead = expQ.pop_front();
                assert (retire.dest == expHead.dest)
                    else reportValue("o_retire.dest", word_t'(expHead.dest), word_t'(retire.dest));
                assert (retire.data == expHead.data)
                    else reportValue("o_retire.data", expHead.data, retire.data);
            end
        end
        if (endFlag === 1'b1 && !endSeen) begin
            endSeen = 1'b1;
            assert (expQ.size() == 0)
                else begin
                    otherErrors++;
                    $display("o_end rose with %0d retirements still missing", expQ.size());
                end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic resetDut();
        rst       = 1'b1;
        halt      = 1'b1;
        loadValid = 1'b0;
        loadData  = '0;
        repeat (8) @(negedge clk);
        endSeen = 1'b0;
        rst     = 1'b0;
        @(negedge clk);
    endtask

    task automatic checkResetState();
        assert (retire.valid == 1'b0)
            else reportValue("o_retire.valid", 0, word_t'(retire.valid));
        assert (endFlag == 1'b0)
            else reportValue("o_end", 0, word_t'(endFlag));
        assert (dut0.stall == 1'b0)
            else reportValue("stall", 0, word_t'(dut0.stall));
        assert (loadReady == halt)
            else reportValue("o_loadReady", word_t'(halt), word_t'(loadReady));
    endtask

    // random idle gaps on the valid side
    task automatic loadWords();
        int   gap;
        int   waitCount;
        logic accepted;
        foreach (progWords[i]) begin
            gap = int'($urandom % 4);
            repeat (gap) @(negedge clk);
            loadValid = 1'b1;
            loadData  = progWords[i];
            accepted  = 1'b0;
            waitCount = 0;
            while (!accepted && waitCount < 50) begin
                accepted = loadReady;   // transfer on the next rising edge
                @(negedge clk);
                waitCount++;
            end
            if (!accepted) begin
                timeoutErrors++;
                $display("timed out waiting for o_loadReady on word %0d", i);
            end
            loadValid = 1'b0;
        end
    endtask

    task automatic runProgram(input string title);
        int waitCount;
        resetDut();
        checkResetState();
        runModel();
        loadWords();
        halt      = 1'b0;
        waitCount = 0;
        while (endFlag !== 1'b1 && waitCount < 2000) begin
            @(negedge clk);
            waitCount++;
        end
        if (endFlag !== 1'b1) begin
            timeoutErrors++;
            $display("%s program timed out waiting for o_end", title);
        end
        repeat (6) @(negedge clk);  // nothing may retire after the end
        assert (expQ.size() == 0)
            else begin
                otherErrors++;
                $display("%s program left %0d retirements missing", title, expQ.size());
            end
        $display("%s program done", title);
    endtask

    initial begin
        rst           = 1'b1;
        halt          = 1'b1;
        loadValid     = 1'b0;
        loadData      = '0;
        endSeen       = 1'b0;
        valueErrors   = 0;
        otherErrors   = 0;
        timeoutErrors = 0;
        void'($urandom(32'h6407_faf7));
        buildRandomProg();
        randomWords = progWords;
        // second pass reloads each program over the previous one
        for (int pass = 0; pass < 2; pass++) begin
            buildForwardProg();
            runProgram("forwarding");
            buildLoadUseProg();
            runProgram("load-use");
            buildZeroRegProg();
            runProgram("r0 write");
            progWords = randomWords;
            runProgram("random");
        end
        $display("errors: %0d wrong value, %0d protocol, %0d timeout",
                 valueErrors, otherErrors, timeoutErrors);
        if (valueErrors + otherErrors + timeoutErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: hdl/pipelineCpu.sv
module pipelineCpu (
    input  logic            clk,
    input  logic            i_rst,
    input  logic            i_halt,
    input  logic            i_loadValid,
    input  cpuPkg::word_t   i_loadData,
    output logic            o_loadReady,
    output cpuPkg::wbPort_t o_retire,
    output logic            o_end
);
    import cpuPkg::*;

    fetchToDecode_t ifId;
    decodeToExec_t  idEx;
    execToResult_t  exMem;
    logic           stall;
    logic           stopFetch;

    fetchStage fetch0 (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_halt      (i_halt),
        .i_loadValid (i_loadValid),
        .i_loadData  (i_loadData),
        .o_loadReady (o_loadReady),
        .i_stall     (stall),
        .i_stopFetch (stopFetch),
        .o_toDecode  (ifId)
    );

    decodeStage decode0 (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_fromFetch (ifId),
        .i_wb        (o_retire),    // MEM/WB write port
        .o_stall     (stall),
        .o_stopFetch (stopFetch),
        .o_toExec    (idEx)
    );

    executeStage execute0 (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_fromDecode (idEx),
        .i_wb         (o_retire),
        .o_toResult   (exMem)
    );

    resultStage result0 (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_fromExec (exMem),
        .o_wb       (o_retire),
        .o_end      (o_end)
    );

endmodule

// File: hdl/resultStage.sv
module resultStage (
    input  logic                  clk,
    input  logic                  i_rst,
    input  cpuPkg::execToResult_t i_fromExec,
    output cpuPkg::wbPort_t       o_wb,
    output logic                  o_end
);
    import cpuPkg::*;

    word_t     dmem [DMEM_DEPTH];
    dmemAddr_t memAddr;
    word_t     loadData;
    logic      retireValid;

    // ------------------------------
    // data memory, word access only
    // ------------------------------
    assign memAddr  = i_fromExec.aluResult[9:2];
    assign loadData = dmem[memAddr];

    always_ff @(posedge clk) begin
        if (i_fromExec.valid && i_fromExec.ctrl.memWrite) begin
            dmem[memAddr] <= i_fromExec.storeData;
        end
    end

    // ------------------------------
    // MEM/WB register
    // ------------------------------
    // r0 writes and stores never retire
    assign retireValid = i_fromExec.valid && i_fromExec.ctrl.regWrite
                       && (i_fromExec.dest != '0);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wb.valid <= 1'b0;
        end else begin
            o_wb.valid <= retireValid;
        end
    end

    always_ff @(posedge clk) begin
        o_wb.dest <= i_fromExec.dest;
        o_wb.data <= i_fromExec.ctrl.memRead ? loadData : i_fromExec.aluResult;
    end

    // sticky end flag, rises as HALT enters MEM/WB
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_end <= 1'b0;
        end else if (i_fromExec.valid && i_fromExec.ctrl.halt) begin
            o_end <= 1'b1;
        end
    end

    // fetch stops at HALT, so nothing can retire behind it
    assert property (@(posedge clk) disable iff (i_rst) o_end |-> !o_wb.valid)
        else $error("retirement seen after end");

endmodule

// File: hdl/executeStage.sv
module executeStage (
    input  logic                  clk,
    input  logic                  i_rst,
    input  cpuPkg::decodeToExec_t i_fromDecode,
    input  cpuPkg::wbPort_t       i_wb,
    output cpuPkg::execToResult_t o_toResult
);
    import cpuPkg::*;

    word_t fwdA;
    word_t fwdB;
    word_t operandB;
    word_t aluResult;

    // ------------------------------
    // forwarding
    // ------------------------------
    function automatic word_t forwardOperand(
        input regAddr_t      src,
        input word_t         regVal,
        input execToResult_t exMem,
        input wbPort_t       wb
    );
        if (src == '0) begin
            return regVal;
        end
        // EX/MEM holds the younger result
        if (exMem.valid && exMem.ctrl.regWrite && !exMem.ctrl.memRead
            && exMem.dest == src) begin
            return exMem.aluResult;
        end
        if (wb.valid && wb.dest == src) begin
            return wb.data;
        end
        return regVal;
    endfunction

    assign fwdA = forwardOperand(i_fromDecode.rs, i_fromDecode.opA, o_toResult, i_wb);
    assign fwdB = forwardOperand(i_fromDecode.rt, i_fromDecode.opB, o_toResult, i_wb);

    assign operandB = i_fromDecode.ctrl.useImm ? i_fromDecode.imm : fwdB;

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (i_fromDecode.aluOp)
            ALU_ADD: aluResult = fwdA + operandB;
            ALU_SUB: aluResult = fwdA - operandB;
            ALU_AND: aluResult = fwdA & operandB;
            ALU_OR:  aluResult = fwdA | operandB;
            ALU_XOR: aluResult = fwdA ^ operandB;
            ALU_SLT: begin
                // signed compare
                aluResult = ($signed(fwdA) < $signed(operandB)) ? 32'd1 : 32'd0;
            end
            default: aluResult = '0;
        endcase
    end

    // ------------------------------
    // EX/MEM register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_toResult.valid <= 1'b0;
            o_toResult.ctrl  <= '0;
        end else begin
            o_toResult.valid <= i_fromDecode.valid;
            o_toResult.ctrl  <= i_fromDecode.valid ? i_fromDecode.ctrl : '0;
        end
    end

    always_ff @(posedge clk) begin
        o_toResult.dest      <= i_fromDecode.dest;
        o_toResult.aluResult <= aluResult;
        o_toResult.storeData <= fwdB;      // SW data after forwarding
    end

    // decode stalls a load consumer, so load data never needs EX/MEM forwarding
    assert property (@(posedge clk) disable iff (i_rst)
        (o_toResult.valid && o_toResult.ctrl.memRead && o_toResult.dest != '0
         && i_fromDecode.valid)
        |-> (i_fromDecode.rs != o_toResult.dest && i_fromDecode.rt != o_toResult.dest))
        else $error("load result needed from EX/MEM without a stall");

endmodule

// File: hdl/decodeStage.sv
module decodeStage (
    input  logic                  clk,
    input  logic                  i_rst,
    input  cpuPkg::fetchToDecode_t i_fromFetch,
    input  cpuPkg::wbPort_t       i_wb,
    output logic                  o_stall,
    output logic                  o_stopFetch,
    output cpuPkg::decodeToExec_t o_toExec
);
    import cpuPkg::*;

    word_t         regFile [32];
    logic [5:0]    opcode;
    logic [5:0]    funct;
    logic [15:0]   imm16;
    regAddr_t      rs;
    regAddr_t      rt;
    regAddr_t      rd;
    logic          usesRs;
    logic          usesRt;
    stageCtrl_t    ctrl;
    aluOp_e        aluOp;
    regAddr_t      dest;
    word_t         rsData;
    word_t         rtData;
    logic          haltSeen;
    decodeToExec_t nextEx;

    assign opcode = i_fromFetch.instr[31:26];
    assign rs     = i_fromFetch.instr[25:21];
    assign rt     = i_fromFetch.instr[20:16];
    assign rd     = i_fromFetch.instr[15:11];
    assign funct  = i_fromFetch.instr[5:0];
    assign imm16  = i_fromFetch.instr[15:0];

    // ------------------------------
    // control decode
    // ------------------------------
    always_comb begin
        ctrl   = '0;
        aluOp  = ALU_ADD;
        dest   = '0;
        usesRs = 1'b0;
        usesRt = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                usesRs        = 1'b1;
                usesRt        = 1'b1;
                dest          = rd;
                ctrl.regWrite = 1'b1;
                case (funct)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    default: ctrl.regWrite = 1'b0;  // unknown function runs as a nop
                endcase
            end
            OP_ADDIU: begin
                usesRs        = 1'b1;
                dest          = rt;
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
            end
            OP_LW: begin
                usesRs        = 1'b1;
                dest          = rt;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.useImm   = 1'b1;
            end
            OP_SW: begin
                usesRs        = 1'b1;
                usesRt        = 1'b1;   // store data
                ctrl.memWrite = 1'b1;
                ctrl.useImm   = 1'b1;
            end
            OP_HALT: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

    // ------------------------------
    // register file, r0 reads zero
    // ------------------------------
    assign rsData = (rs == '0) ? '0 : (i_wb.valid && i_wb.dest == rs) ? i_wb.data : regFile[rs];
    assign rtData = (rt == '0) ? '0 : (i_wb.valid && i_wb.dest == rt) ? i_wb.data : regFile[rt];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else if (i_wb.valid && i_wb.dest != '0) begin
            regFile[i_wb.dest] <= i_wb.data;
        end
    end

    // load in ID/EX feeding a source of the incoming instruction
    assign o_stall = o_toExec.valid && o_toExec.ctrl.memRead && (o_toExec.dest != '0)
                   && i_fromFetch.valid
                   && ((usesRs && rs == o_toExec.dest) || (usesRt && rt == o_toExec.dest));

    assign o_stopFetch = haltSeen || (i_fromFetch.valid && opcode == OP_HALT);

    // ------------------------------
    // ID/EX register
    // ------------------------------
    always_comb begin
        nextEx.valid = i_fromFetch.valid && !o_stall;   // stall leaves a bubble
        nextEx.ctrl  = nextEx.valid ? ctrl : '0;
        nextEx.aluOp = aluOp;
        nextEx.rs    = usesRs ? rs : '0;
        nextEx.rt    = usesRt ? rt : '0;
        nextEx.dest  = dest;
        nextEx.opA   = rsData;
        nextEx.opB   = rtData;
        nextEx.imm   = {{16{imm16[15]}}, imm16};
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_toExec.valid <= 1'b0;
            o_toExec.ctrl  <= '0;
            haltSeen       <= 1'b0;
        end else begin
            o_toExec <= nextEx;
            if (nextEx.valid && ctrl.halt) begin
                haltSeen <= 1'b1;
            end
        end
    end

    // one stall cycle, with fetch holding the stalled instruction in IF/ID
    assert property (@(posedge clk) disable iff (i_rst)
        o_stall |=> (!o_stall && $stable(i_fromFetch)))
        else $error("load-use stall not held for exactly one cycle");

endmodule

// File: hdl/fetchStage.sv
module fetchStage (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_halt,
    input  logic                   i_loadValid,
    input  cpuPkg::word_t          i_loadData,
    output logic                   o_loadReady,
    input  logic                   i_stall,
    input  logic                   i_stopFetch,
    output cpuPkg::fetchToDecode_t o_toDecode
);
    import cpuPkg::*;

    word_t                      imem [IMEM_DEPTH];
    logic [$clog2(IMEM_DEPTH):0] loadAddr;   // one extra bit to mark a full memory
    imemAddr_t                  pc;
    logic                       loadFire;

    // ------------------------------
    // program load while halted
    // ------------------------------
    assign o_loadReady = i_halt && (loadAddr < IMEM_DEPTH);
    assign loadFire    = i_loadValid && o_loadReady;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            loadAddr <= '0;
        end else if (loadFire) begin
            loadAddr <= loadAddr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (loadFire) begin
            imem[imemAddr_t'(loadAddr)] <= i_loadData;
        end
    end

    // ------------------------------
    // pc and IF/ID register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc               <= '0;
            o_toDecode.valid <= 1'b0;
        end else if (i_halt) begin
            pc               <= '0;       // restart from address 0
            o_toDecode.valid <= 1'b0;
        end else if (!i_stall) begin
            if (i_stopFetch) begin
                o_toDecode.valid <= 1'b0; // halt decoded, only bubbles from here
            end else begin
                o_toDecode.valid <= 1'b1;
                o_toDecode.instr <= imem[pc];
                pc               <= pc + 1'b1;
            end
        end
    end

    // a word offered past the last address would wrap onto address 0
    assert property (@(posedge clk) disable iff (i_rst)
        (i_halt && i_loadValid) |-> (loadAddr < IMEM_DEPTH))
        else $error("program load ran past the end of instruction memory");

endmodule

// File: hdl/cpuPkg.sv
package cpuPkg;

    // ------------------------------
    // widths
    // ------------------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [7:0]  imemAddr_t;
    typedef logic [7:0]  dmemAddr_t;    // byte address bits 9:2

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;

    // ------------------------------
    // opcodes and function codes
    // ------------------------------
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_HALT  = 6'h3f;

    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOp_e;

    // ------------------------------
    // stage structs
    // ------------------------------
    typedef struct packed {
        logic  valid;
        word_t instr;
    } fetchToDecode_t;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic useImm;     // operand B comes from the immediate
        logic halt;
    } stageCtrl_t;

    typedef struct packed {
        logic       valid;
        stageCtrl_t ctrl;
        aluOp_e     aluOp;
        regAddr_t   rs;       // zero when the field is not a source
        regAddr_t   rt;
        regAddr_t   dest;
        word_t      opA;
        word_t      opB;
        word_t      imm;
    } decodeToExec_t;

    typedef struct packed {
        logic       valid;
        stageCtrl_t ctrl;
        regAddr_t   dest;
        word_t      aluResult;
        word_t      storeData;
    } execToResult_t;

    // register write port, also the retire output
    typedef struct packed {
        logic     valid;
        regAddr_t dest;
        word_t    data;
    } wbPort_t;

endpackage
